// ==== common/sftm_cfg.svh ====
`ifndef SFTM_CFG_SVH
`define SFTM_CFG_SVH

// ====================
// Datapath widths
// ====================
`define SFTM_DATA_W       16
`define SFTM_ACC_W        32

// ====================
// Tile geometry
// ====================
`define SFTM_PATCH_N      4
`define SFTM_OUT_N        2

// Sparse list layout, one list per accepted patch
`define SFTM_OUT_CH       3
`define SFTM_TAPS_PER_CH  6
`define SFTM_LIST_LEN     18
`define SFTM_IDX_W        6

// Weight memory addressing and output framing
`define SFTM_WADDR_W      12
`define SFTM_GROUP_LEN    12

`endif

// ==== common/sftm_pkg.sv ====
`include "sftm_cfg.svh"

package sftm_pkg;

    // ====================
    // Scalar types
    // ====================
    typedef logic signed [`SFTM_DATA_W-1:0] sample_t;
    typedef logic signed [`SFTM_ACC_W-1:0]  acc_t;

    // Element (row, column), row-major
    typedef sample_t [`SFTM_PATCH_N-1:0][`SFTM_PATCH_N-1:0] patch_t;
    typedef sample_t [`SFTM_OUT_N-1:0][`SFTM_OUT_N-1:0]     tile2_t;

    typedef struct packed {
        tile2_t ch0;
        tile2_t ch1;
        tile2_t ch2;
    } tile2_set_t;

    // SCA result, one coefficient tile per output channel
    typedef struct packed {
        patch_t ch0;
        patch_t ch1;
        patch_t ch2;
    } coef_set_t;

    // Entry j belongs to output channel j / taps per channel
    typedef struct packed {
        sample_t [`SFTM_LIST_LEN-1:0]                  weights;
        logic [`SFTM_LIST_LEN-1:0][`SFTM_IDX_W-1:0]    indexes;
    } sca_list_t;

    // Arithmetic right shift by 0, 1, 2 or 3
    typedef enum logic [1:0] {
        Q_FULL    = 2'd0,
        Q_HALF    = 2'd1,
        Q_QUARTER = 2'd2,
        Q_EIGHTH  = 2'd3
    } quality_e;

    typedef enum logic {
        OUT_IDLE   = 1'b0,
        OUT_STREAM = 1'b1
    } out_state_e;

    localparam acc_t SAMPLE_MAX = acc_t'(2 ** (`SFTM_DATA_W - 1) - 1);
    localparam acc_t SAMPLE_MIN = -acc_t'(2 ** (`SFTM_DATA_W - 1));

    // Clamp an accumulator to the sample range
    function automatic sample_t sat_sample(input acc_t v);
        sample_t res;
        if (v > SAMPLE_MAX) begin
            res = SAMPLE_MAX[`SFTM_DATA_W-1:0];
        end else if (v < SAMPLE_MIN) begin
            res = SAMPLE_MIN[`SFTM_DATA_W-1:0];
        end else begin
            res = v[`SFTM_DATA_W-1:0];
        end
        return res;
    endfunction

endpackage

// ==== hw/group_output.sv ====
`include "sftm_cfg.svh"

module group_output
    import sftm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  tile2_set_t tiles,
    input  logic       tiles_valid,
    input  quality_e   quality_mode,
    output logic       group_valid,
    output logic       group_done,
    output logic       group_data_valid,
    output sample_t    group_data
);

    localparam int CNT_W = $clog2(`SFTM_GROUP_LEN);

    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`SFTM_GROUP_LEN - 1);

    out_state_e       state;
    tile2_set_t       tiles_q;
    logic [CNT_W-1:0] cnt;
    tile2_t           sel_tile;
    sample_t          ser_sample;
    logic             ser_valid;
    logic             ser_last;

    // Quality modulation as a signed shift
    function automatic sample_t qmu_shift(input sample_t v, input quality_e q);
        sample_t res;
        case (q)
            Q_FULL:    res = v;
            Q_HALF:    res = v >>> 1;
            Q_QUARTER: res = v >>> 2;
            default:   res = v >>> 3;
        endcase
        return res;
    endfunction

    // Upper counter bits pick the channel
    always_comb begin
        case (cnt[CNT_W-1:2])
            2'd0:    sel_tile = tiles_q.ch0;
            2'd1:    sel_tile = tiles_q.ch1;
            default: sel_tile = tiles_q.ch2;
        endcase
    end

    // ====================
    // Serializer FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= OUT_IDLE;
            cnt       <= '0;
            ser_valid <= 1'b0;
            ser_last  <= 1'b0;
        end else begin
            ser_valid <= 1'b0;
            ser_last  <= 1'b0;
            case (state)
                OUT_IDLE: begin
                    if (tiles_valid) begin
                        state <= OUT_STREAM;
                        cnt   <= '0;
                    end
                end
                OUT_STREAM: begin
                    ser_valid <= 1'b1;
                    ser_last  <= (cnt == LAST_IDX);
                    if (cnt == LAST_IDX) begin
                        state <= OUT_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= OUT_IDLE;
            endcase
        end
    end

    // Within a channel: (0,0) (0,1) (1,0) (1,1)
    always_ff @(posedge clk) begin
        if (state == OUT_IDLE && tiles_valid) begin
            tiles_q <= tiles;
        end
        if (state == OUT_STREAM) begin
            ser_sample <= sel_tile[cnt[1]][cnt[0]];
        end
    end

    // ====================
    // QMU and framing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_valid      <= 1'b0;
            group_done       <= 1'b0;
            group_data_valid <= 1'b0;
        end else begin
            group_valid      <= ser_valid;
            group_done       <= ser_last;
            group_data_valid <= ser_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ser_valid) begin
            group_data <= qmu_shift(ser_sample, quality_mode);
        end
    end

    // The input rate must leave room to drain a whole group
    a_no_tile_while_streaming : assert property (
        @(posedge clk) disable iff (!rst_n)
        tiles_valid |-> (state == OUT_IDLE)
    );

    // Done closes a full run of samples
    a_done_closes_group : assert property (
        @(posedge clk) disable iff (!rst_n)
        group_done |-> group_data_valid && $past(group_data_valid, `SFTM_GROUP_LEN - 1)
    );

endmodule

// ==== hw/patch_buffer.sv ====
`include "sftm_cfg.svh"

module patch_buffer
    import sftm_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  sample_t sample,
    input  logic    sample_valid,
    output patch_t  patch,
    output logic    patch_valid
);

    localparam int N     = `SFTM_PATCH_N;
    localparam int CNT_W = $clog2(N * N);
    localparam int RC_W  = $clog2(N);

    localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(N * N - 1);

    logic [CNT_W-1:0] wr_pos;
    logic             accept;

    // Samples offered while start is low are dropped
    assign accept = sample_valid && start;

    // Write position counter, wraps after the last element of a patch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pos      <= '0;
            patch_valid <= 1'b0;
        end else begin
            patch_valid <= accept && (wr_pos == LAST_POS);
            if (accept) begin
                wr_pos <= wr_pos + 1'b1;
            end
        end
    end

    // Row from the upper counter bits, column from the lower ones
    always_ff @(posedge clk) begin
        if (accept) begin
            patch[wr_pos[CNT_W-1:RC_W]][wr_pos[RC_W-1:0]] <= sample;
        end
    end

    // Patches need N*N accepted samples each, so the strobe is always isolated
    a_patch_strobe_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        patch_valid |=> !patch_valid
    );

endmodule

// ==== hw/sca_list_engine.sv ====
`include "sftm_cfg.svh"

module sca_list_engine
    import sftm_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  patch_t                   coef,
    input  logic                     valid_in,
    input  sca_list_t                scu_list,
    output coef_set_t                prod,
    output logic                     valid_out,
    output logic [`SFTM_WADDR_W-1:0] weight_addr
);

    localparam int N     = `SFTM_PATCH_N;
    localparam int NCOEF = N * N;
    localparam int CH    = `SFTM_OUT_CH;
    localparam int TAPS  = `SFTM_TAPS_PER_CH;

    localparam logic [`SFTM_WADDR_W-1:0] ADDR_STEP = `SFTM_LIST_LEN;

    acc_t   sum_d  [CH][NCOEF];
    patch_t prod_d [CH];

    // ====================
    // Sparse list multiply
    // ====================
    // An entry only touches the coefficient its index names; indexes past
    // the tile never match and drop out
    always_comb begin
        for (int c = 0; c < CH; c++) begin
            for (int k = 0; k < NCOEF; k++) begin
                sum_d[c][k] = '0;
                for (int t = 0; t < TAPS; t++) begin
                    if (int'(scu_list.indexes[c * TAPS + t]) == k) begin
                        sum_d[c][k] = sum_d[c][k]
                                    + acc_t'(scu_list.weights[c * TAPS + t])
                                    * acc_t'(coef[k / N][k % N]);
                    end
                end
                prod_d[c][k / N][k % N] = sat_sample(sum_d[c][k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            prod <= '{ch0: prod_d[0], ch1: prod_d[1], ch2: prod_d[2]};
        end
    end

    // ====================
    // Weight address
    // ====================
    // One list length per accepted tile, wrapping at the address width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out   <= 1'b0;
            weight_addr <= '0;
        end else begin
            valid_out <= valid_in;
            if (valid_in) begin
                weight_addr <= weight_addr + ADDR_STEP;
            end
        end
    end

endmodule

// ==== hw/sftm.sv ====
`include "sftm_cfg.svh"

module sftm
    import sftm_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  sample_t                  input_data,
    input  logic                     input_valid,
    input  quality_e                 quality_mode,
    input  sca_list_t                scu_list,
    output logic [`SFTM_WADDR_W-1:0] weight_addr,
    output logic                     group_valid,
    output logic                     group_done,
    output sample_t                  group_data,
    output logic                     group_data_valid
);

    patch_t     patch;
    logic       patch_valid;
    patch_t     coef;
    logic       coef_valid;
    coef_set_t  prod;
    logic       prod_valid;
    tile2_set_t tiles;
    logic       tiles_valid;

    // ====================
    // Pipeline stages
    // ====================
    patch_buffer u_patch_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .sample       (input_data),
        .sample_valid (input_valid),
        .patch        (patch),
        .patch_valid  (patch_valid)
    );

    preta_conv u_preta_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .patch_in  (patch),
        .valid_in  (patch_valid),
        .coef      (coef),
        .valid_out (coef_valid)
    );

    sca_list_engine u_sca_list_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .coef        (coef),
        .valid_in    (coef_valid),
        .scu_list    (scu_list),
        .prod        (prod),
        .valid_out   (prod_valid),
        .weight_addr (weight_addr)
    );

    posta_conv u_posta_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod      (prod),
        .valid_in  (prod_valid),
        .tiles     (tiles),
        .valid_out (tiles_valid)
    );

    // Serialization, QMU and group framing
    group_output u_group_output (
        .clk              (clk),
        .rst_n            (rst_n),
        .tiles            (tiles),
        .tiles_valid      (tiles_valid),
        .quality_mode     (quality_mode),
        .group_valid      (group_valid),
        .group_done       (group_done),
        .group_data_valid (group_data_valid),
        .group_data       (group_data)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sftm -Mdir "$OBJ" -o tb_sftm -f sftm.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_sftm" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== sftm.f ====
+incdir+common
+incdir+tests
common/sftm_pkg.sv
hw/patch_buffer.sv
winograd/preta_conv.sv
hw/sca_list_engine.sv
winograd/posta_conv.sv
hw/group_output.sv
hw/sftm.sv
tests/tb_sftm.sv

// ==== tests/sftm_ref_model.svh ====
`ifndef SFTM_REF_MODEL_SVH
`define SFTM_REF_MODEL_SVH

// Expected samples of one group, serial position n at index n
typedef sample_t [`SFTM_GROUP_LEN-1:0] group_vec_t;

// Clamp to the signed sample range
function automatic sample_t clamp_sample(input longint v);
    longint  hi;
    longint  lo;
    sample_t res;
    hi = (longint'(1) << (`SFTM_DATA_W - 1)) - 1;
    lo = -hi - 1;
    if (v > hi) begin
        res = sample_t'(hi);
    end else if (v < lo) begin
        res = sample_t'(lo);
    end else begin
        res = sample_t'(v);
    end
    return res;
endfunction

// Y = B * X * B^T with the fixed input transform rows
function automatic patch_t input_transform(input patch_t x);
    int     bt  [4][4];
    longint tmp [4][4];
    longint s;
    patch_t y;
    bt = '{'{1, 0, -1, 0}, '{0, 1, 1, 0}, '{0, -1, 1, 0}, '{0, 1, 0, -1}};
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            s = 0;
            for (int i = 0; i < 4; i++) begin
                s += bt[r][i] * longint'(x[i][c]);
            end
            tmp[r][c] = s;
        end
    end
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            s = 0;
            for (int j = 0; j < 4; j++) begin
                s += tmp[r][j] * bt[c][j];
            end
            y[r][c] = clamp_sample(s);
        end
    end
    return y;
endfunction

// Entries ch*6 .. ch*6+5 scale the coefficient their index names
function automatic patch_t sparse_multiply(input patch_t coef, input sca_list_t lst,
                                           input int ch);
    longint acc [16];
    patch_t y;
    int     e;
    int     k;
    for (int n = 0; n < 16; n++) begin
        acc[n] = 0;
    end
    for (int t = 0; t < `SFTM_TAPS_PER_CH; t++) begin
        e = ch * `SFTM_TAPS_PER_CH + t;
        k = int'(lst.indexes[e]);
        if (k < 16) begin
            acc[k] += longint'(lst.weights[e]) * longint'(coef[k / 4][k % 4]);
        end
    end
    for (int n = 0; n < 16; n++) begin
        y[n / 4][n % 4] = clamp_sample(acc[n]);
    end
    return y;
endfunction

// Y = A * X * A^T, 4x4 down to 2x2
function automatic tile2_t output_transform(input patch_t x);
    int     a   [2][4];
    longint tmp [2][4];
    longint s;
    tile2_t y;
    a = '{'{1, 1, 1, 0}, '{0, 1, -1, -1}};
    for (int r = 0; r < 2; r++) begin
        for (int c = 0; c < 4; c++) begin
            s = 0;
            for (int i = 0; i < 4; i++) begin
                s += a[r][i] * longint'(x[i][c]);
            end
            tmp[r][c] = s;
        end
    end
    for (int r = 0; r < 2; r++) begin
        for (int c = 0; c < 2; c++) begin
            s = 0;
            for (int j = 0; j < 4; j++) begin
                s += tmp[r][j] * a[c][j];
            end
            y[r][c] = clamp_sample(s);
        end
    end
    return y;
endfunction

// Quality mode encodes the arithmetic shift amount
function automatic sample_t quality_shift(input sample_t v, input quality_e q);
    sample_t res;
    res = v >>> int'(q);
    return res;
endfunction

function automatic group_vec_t expected_group(input patch_t p, input sca_list_t lst,
                                              input quality_e q);
    patch_t     coef;
    patch_t     prod;
    tile2_t     tile;
    group_vec_t g;
    coef = input_transform(p);
    for (int ch = 0; ch < `SFTM_OUT_CH; ch++) begin
        prod = sparse_multiply(coef, lst, ch);
        tile = output_transform(prod);
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                g[ch * 4 + r * 2 + c] = quality_shift(tile[r][c], q);
            end
        end
    end
    return g;
endfunction

`endif

// ==== tests/tb_sftm.sv ====
`include "sftm_cfg.svh"

module tb_sftm
    import sftm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF         = 20;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_PATCHES      = 17;
    localparam int CYCLES_PER_PATCH = 40;
    localparam int WATCHDOG_CYCLES  = NUM_PATCHES * CYCLES_PER_PATCH + RESET_CYCLES;
    localparam int DRAIN_LIMIT      = 64;
    localparam int GLEN             = `SFTM_GROUP_LEN;
    localparam int FS_POS           = 2 ** (`SFTM_DATA_W - 1) - 1;
    localparam int FS_NEG           = -(2 ** (`SFTM_DATA_W - 1));

    typedef logic [`SFTM_WADDR_W-1:0] waddr_t;
    typedef logic [`SFTM_IDX_W-1:0]   idx_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      input_valid;
    sample_t   input_data;
    quality_e  quality_mode;
    sca_list_t scu_list;
    waddr_t    weight_addr;
    logic      group_valid;
    logic      group_done;
    sample_t   group_data;
    logic      group_data_valid;

    // Config currently applied to the DUT
    sca_list_t cur_list;
    quality_e  cur_q;

    sample_t   exp_q [$];
    int        err_cnt;
    int        check_cnt;
    int        group_cnt;
    int        grp_pos;
    int        test_cnt;
    int        tests_failed;

    `include "sftm_ref_model.svh"

    sftm dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .input_data       (input_data),
        .input_valid      (input_valid),
        .quality_mode     (quality_mode),
        .scu_list         (scu_list),
        .weight_addr      (weight_addr),
        .group_valid      (group_valid),
        .group_done       (group_done),
        .group_data       (group_data),
        .group_data_valid (group_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ====================
    // Checks
    // ====================
    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input waddr_t got, input waddr_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("Test %-26s PASS", name);
        end else begin
            $display("Test %-26s FAIL (%0d errors)", name, err_cnt - err_before);
            tests_failed++;
        end
    endtask

    // ====================
    // Stimulus helpers
    // ====================
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic patch_t random_patch(input int lo, input int hi);
        patch_t p;
        for (int n = 0; n < 16; n++) begin
            p[n / 4][n % 4] = sample_t'(rand_range(lo, hi));
        end
        return p;
    endfunction

    function automatic patch_t const_patch(input int v);
        patch_t p;
        for (int n = 0; n < 16; n++) begin
            p[n / 4][n % 4] = sample_t'(v);
        end
        return p;
    endfunction

    function automatic patch_t full_scale_patch();
        patch_t p;
        for (int n = 0; n < 16; n++) begin
            p[n / 4][n % 4] = sample_t'(($urandom % 2) ? FS_POS : FS_NEG);
        end
        return p;
    endfunction

    // Indexes from 16 to 23 fall outside the tile
    function automatic sca_list_t random_list();
        sca_list_t l;
        for (int e = 0; e < `SFTM_LIST_LEN; e++) begin
            l.weights[e] = sample_t'(rand_range(-64, 63));
            l.indexes[e] = idx_t'($urandom % 24);
        end
        return l;
    endfunction

    // Distinct indexes per channel, full-scale weights
    function automatic sca_list_t saturating_list();
        sca_list_t l;
        int        e;
        for (int ch = 0; ch < `SFTM_OUT_CH; ch++) begin
            for (int t = 0; t < `SFTM_TAPS_PER_CH; t++) begin
                e = ch * `SFTM_TAPS_PER_CH + t;
                l.weights[e] = sample_t'((t % 2 == 1) ? FS_NEG : FS_POS);
                l.indexes[e] = idx_t'((5 + t * 3 + ch) % 16);
            end
        end
        return l;
    endfunction

    task automatic apply_config(input sca_list_t l, input quality_e q);
        @(posedge clk);
        scu_list     <= l;
        quality_mode <= q;
        cur_list = l;
        cur_q    = q;
    endtask

    task automatic offer_ignored();
        @(posedge clk);
        start       <= 1'b0;
        input_valid <= 1'b1;
        input_data  <= sample_t'(rand_range(-1000, 1000));
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        start       <= 1'b0;
        input_valid <= 1'b0;
    endtask

    // One gated sample goes in before position skip_pos, none if it is 16
    task automatic send_patch(input patch_t p, input int skip_pos);
        group_vec_t g;
        g = expected_group(p, cur_list, cur_q);
        for (int n = 0; n < GLEN; n++) begin
            exp_q.push_back(g[n]);
        end
        for (int n = 0; n < 16; n++) begin
            if (n == skip_pos) begin
                offer_ignored();
            end
            @(posedge clk);
            start       <= 1'b1;
            input_valid <= 1'b1;
            input_data  <= p[n / 4][n % 4];
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected samples never came out", exp_q.size()));
            exp_q.delete();
        end
        @(posedge clk);
    endtask

    // ====================
    // Compare process
    // ====================
    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin : compare_outputs
        sample_t exp_s;
        if (rst_n) begin
            if (group_data_valid) begin
                grp_pos++;
                check_flag("group_valid", group_valid, 1'b1);
                if (exp_q.size() == 0) begin
                    report_error("group_data_valid high with no sample expected");
                end else begin
                    exp_s = exp_q.pop_front();
                    check_sample("group_data", group_data, exp_s);
                end
                check_flag("group_done", group_done, grp_pos == GLEN);
                if (grp_pos == GLEN) begin
                    grp_pos = 0;
                    group_cnt++;
                    check_addr("weight_addr", weight_addr,
                               waddr_t'(group_cnt * `SFTM_LIST_LEN));
                end
            end else begin
                check_flag("group_valid", group_valid, 1'b0);
                check_flag("group_done", group_done, 1'b0);
                // A group runs on consecutive cycles
                if (grp_pos != 0) begin
                    report_error($sformatf("group broken off after %0d samples", grp_pos));
                    grp_pos = 0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================
    initial begin : stimulus
        patch_t    keep;
        sca_list_t lst;
        quality_e  q_list [3];
        int        err_before;
        void'($urandom(20));
        q_list       = '{Q_HALF, Q_QUARTER, Q_EIGHTH};
        err_cnt      = 0;
        check_cnt    = 0;
        group_cnt    = 0;
        grp_pos      = 0;
        test_cnt     = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        input_valid  = 1'b0;
        input_data   = '0;
        quality_mode = Q_FULL;
        scu_list     = '0;
        cur_list     = '0;
        cur_q        = Q_FULL;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);

        err_before = err_cnt;
        check_flag("group_valid", group_valid, 1'b0);
        check_flag("group_done", group_done, 1'b0);
        check_flag("group_data_valid", group_data_valid, 1'b0);
        check_addr("weight_addr", weight_addr, '0);
        report_test("reset_state", err_before);

        err_before = err_cnt;
        lst  = random_list();
        keep = random_patch(-128, 127);
        apply_config(lst, Q_FULL);
        send_patch(keep, 16);
        idle_inputs();
        wait_drain();
        report_test("single_tile_full_quality", err_before);

        err_before = err_cnt;
        for (int i = 0; i < 3; i++) begin
            apply_config(lst, q_list[i]);
            send_patch(keep, 16);
            idle_inputs();
            wait_drain();
        end
        report_test("quality_modes", err_before);

        err_before = err_cnt;
        apply_config(saturating_list(), Q_FULL);
        send_patch(const_patch(FS_POS), 16);
        idle_inputs();
        wait_drain();
        send_patch(const_patch(FS_NEG), 16);
        idle_inputs();
        wait_drain();
        send_patch(full_scale_patch(), 16);
        idle_inputs();
        wait_drain();
        report_test("saturation", err_before);

        // Gated samples inside and between patches
        err_before = err_cnt;
        apply_config(random_list(), Q_FULL);
        for (int i = 0; i < 10; i++) begin
            send_patch(random_patch(-2000, 2000), rand_range(0, 16));
            offer_ignored();
            offer_ignored();
        end
        idle_inputs();
        wait_drain();
        check_addr("weight_addr", weight_addr, waddr_t'(NUM_PATCHES * `SFTM_LIST_LEN));
        report_test("streaming_and_gating", err_before);

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors, %0d groups",
                 test_cnt, tests_failed, check_cnt, err_cnt, group_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== winograd/posta_conv.sv ====
`include "sftm_cfg.svh"

module posta_conv
    import sftm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  coef_set_t  prod,
    input  logic       valid_in,
    output tile2_set_t tiles,
    output logic       valid_out
);

    localparam int N  = `SFTM_PATCH_N;
    localparam int M  = `SFTM_OUT_N;
    localparam int CH = `SFTM_OUT_CH;

    // Row r of the 2x4 output transform applied to a 4-vector
    function automatic acc_t a_dot(input int r, input acc_t v0, input acc_t v1,
                                   input acc_t v2, input acc_t v3);
        acc_t res;
        if (r == 0) begin
            res = v0 + v1 + v2;
        end else begin
            res = v1 - v2 - v3;
        end
        return res;
    endfunction

    patch_t ch_in     [CH];
    acc_t   col_pass  [CH][M][N];
    tile2_t ch_out    [CH];

    assign ch_in[0] = prod.ch0;
    assign ch_in[1] = prod.ch1;
    assign ch_in[2] = prod.ch2;

    always_comb begin
        for (int k = 0; k < CH; k++) begin
            // Reduce four rows to two
            for (int r = 0; r < M; r++) begin
                for (int c = 0; c < N; c++) begin
                    col_pass[k][r][c] = a_dot(r, acc_t'(ch_in[k][0][c]),
                                              acc_t'(ch_in[k][1][c]),
                                              acc_t'(ch_in[k][2][c]),
                                              acc_t'(ch_in[k][3][c]));
                end
            end
            // Reduce four columns to two and clamp
            for (int r = 0; r < M; r++) begin
                for (int c = 0; c < M; c++) begin
                    ch_out[k][r][c] = sat_sample(a_dot(c, col_pass[k][r][0],
                                                       col_pass[k][r][1],
                                                       col_pass[k][r][2],
                                                       col_pass[k][r][3]));
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            tiles <= '{ch0: ch_out[0], ch1: ch_out[1], ch2: ch_out[2]};
        end
    end

endmodule

// ==== winograd/preta_conv.sv ====
`include "sftm_cfg.svh"

module preta_conv
    import sftm_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  patch_t patch_in,
    input  logic   valid_in,
    output patch_t coef,
    output logic   valid_out
);

    localparam int N = `SFTM_PATCH_N;

    // Row r of the input transform matrix applied to a 4-vector
    function automatic acc_t bt_dot(input int r, input acc_t v0, input acc_t v1,
                                    input acc_t v2, input acc_t v3);
        acc_t res;
        case (r)
            0:       res = v0 - v2;
            1:       res = v1 + v2;
            2:       res = v2 - v1;
            default: res = v1 - v3;
        endcase
        return res;
    endfunction

    acc_t   col_pass [N][N];
    patch_t coef_d;

    always_comb begin
        // Left multiply, transform down each column
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                col_pass[r][c] = bt_dot(r, acc_t'(patch_in[0][c]), acc_t'(patch_in[1][c]),
                                        acc_t'(patch_in[2][c]), acc_t'(patch_in[3][c]));
            end
        end
        // Right multiply by the transpose, then clamp at the stage boundary
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                coef_d[r][c] = sat_sample(bt_dot(c, col_pass[r][0], col_pass[r][1],
                                                 col_pass[r][2], col_pass[r][3]));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            coef <= coef_d;
        end
    end

endmodule
